//--- Bender.yml
package:
  name: issue_frontend

sources:
  - issue_pkg.sv
  - inst_queue.sv
  - inst_decoder.sv
  - dual_issue.sv
  - issue_frontend.sv
  - target: simulation
    files:
      - tb_issue_frontend.sv

//--- dual_issue.sv
`timescale 1ns/1ns

module dual_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    cls_refetch,
    input  issue_pkg::fetch_entry_t head_1,
    input  issue_pkg::fetch_entry_t head_2,
    input  logic                    count_ge1,
    input  logic                    count_ge2,
    output logic                    pop_1,
    output logic                    pop_2,
    output issue_pkg::issue_slot_t  slot_1,
    output issue_pkg::issue_slot_t  slot_2,
    output logic [31:0]             dual_count,
    output logic [31:0]             single_count
);

    issue_pkg::decode_t dec_1;
    issue_pkg::decode_t dec_2;

    logic in_ds;
    logic refetch;
    logic jmp_1;
    logic jmp_2;
    logic adel_1;
    logic adel_2;
    logic fault_2;
    logic raw_conflict;
    logic no_pair;

    inst_decoder u_dec_1 (
        .inst (head_1.inst),
        .dec  (dec_1)
    );

    inst_decoder u_dec_2 (
        .inst (head_2.inst),
        .dec  (dec_2)
    );

    assign jmp_1   = dec_1.is_branch | dec_1.is_j | dec_1.is_jr;
    assign jmp_2   = dec_2.is_branch | dec_2.is_j | dec_2.is_jr;
    assign adel_1  = head_1.pc[1:0] != 2'b00;
    assign adel_2  = head_2.pc[1:0] != 2'b00;
    assign fault_2 = head_2.itlb_refill | head_2.itlb_invalid;

    // r0 writes never create a dependency
    assign raw_conflict = dec_1.w_reg_ena & (dec_1.w_reg_dst != 5'd0) &
                          ((dec_1.w_reg_dst == dec_2.rs) | (dec_1.w_reg_dst == dec_2.rt));

    assign no_pair = in_ds |
                     raw_conflict |
                     jmp_2 |
                     dec_2.is_ls |
                     dec_2.is_mul |
                     dec_2.is_hilo |
                     dec_2.is_ri |
                     adel_2 |
                     fault_2 |
                     dec_1.is_tlbw | dec_1.is_tlbp |
                     dec_2.is_tlbw | dec_2.is_tlbp |
                     dec_1.is_branch_likely | dec_2.is_branch_likely;

    // a lone last entry may still go out in slot 1
    assign pop_1 = count_ge1 & ~stall;
    assign pop_2 = pop_1 & count_ge2 & ~no_pair;

    // delay-slot flag survives stalls and empty cycles until slot 1 issues
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ds <= 1'b0;
        end else if (pop_1) begin
            in_ds <= jmp_1 & ~pop_2;
        end
    end

    // tlb ops never pair, so only slot 1 can raise it
    always_ff @(posedge clk) begin
        if (rst) begin
            refetch <= 1'b0;
        end else if (refetch) begin
            refetch <= ~cls_refetch;
        end else begin
            refetch <= pop_1 & dec_1.is_tlbw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dual_count   <= 32'd0;
            single_count <= 32'd0;
        end else begin
            if (pop_2) begin
                dual_count <= dual_count + 32'd1;
            end
            if (pop_1 && !pop_2) begin
                single_count <= single_count + 32'd1;
            end
        end
    end

    always_comb begin
        slot_1.valid         = pop_1;
        slot_1.pc            = head_1.pc;
        slot_1.inst          = head_1.inst;
        slot_1.dec           = dec_1;
        slot_1.in_delay_slot = in_ds;
        slot_1.inst_adel     = adel_1;
        slot_1.itlb_refill   = head_1.itlb_refill;
        slot_1.itlb_invalid  = head_1.itlb_invalid;
        slot_1.refetch       = refetch;
        slot_1.pred_taken    = head_1.pred_taken;
        slot_1.pred_target   = head_1.pred_target;

        slot_2.valid         = pop_2;
        slot_2.pc            = head_2.pc;
        slot_2.inst          = head_2.inst;
        slot_2.dec           = dec_2;
        slot_2.in_delay_slot = jmp_1 & pop_2;
        slot_2.inst_adel     = adel_2;
        slot_2.itlb_refill   = head_2.itlb_refill;
        slot_2.itlb_invalid  = head_2.itlb_invalid;
        slot_2.refetch       = refetch;
        slot_2.pred_taken    = head_2.pred_taken;
        slot_2.pred_target   = head_2.pred_target;
    end

    a_slot2_needs_slot1: assert property (
        @(posedge clk) disable iff (rst) slot_2.valid |-> slot_1.valid
    );

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  issue_pkg::inst_word_u inst,
    output issue_pkg::decode_t    dec
);

    always_comb begin
        dec     = '0;
        dec.imm = inst.i.imm;

        case (inst.i.op)
            issue_pkg::OP_SPECIAL: begin
                case (inst.r.funct)
                    issue_pkg::FN_ADDU,
                    issue_pkg::FN_SUBU,
                    issue_pkg::FN_AND,
                    issue_pkg::FN_OR: begin
                        dec.rs        = inst.r.rs;
                        dec.rt        = inst.r.rt;
                        dec.w_reg_dst = inst.r.rd;
                        dec.w_reg_ena = 1'b1;
                    end
                    issue_pkg::FN_JR: begin
                        dec.rs    = inst.r.rs;
                        dec.is_jr = 1'b1;
                    end
                    issue_pkg::FN_MULT: begin
                        dec.rs     = inst.r.rs;
                        dec.rt     = inst.r.rt;
                        dec.is_mul = 1'b1;
                    end
                    issue_pkg::FN_MFHI: begin
                        dec.w_reg_dst = inst.r.rd;
                        dec.w_reg_ena = 1'b1;
                        dec.is_hilo   = 1'b1;
                    end
                    default: begin
                        dec.is_ri = 1'b1;
                    end
                endcase
            end

            issue_pkg::OP_ADDIU: begin
                dec.rs        = inst.i.rs;
                dec.w_reg_dst = inst.i.rt;
                dec.w_reg_ena = 1'b1;
            end

            issue_pkg::OP_LW: begin
                dec.rs        = inst.i.rs;
                dec.w_reg_dst = inst.i.rt;
                dec.w_reg_ena = 1'b1;
                dec.is_ls     = 1'b1;
            end

            // store reads both base and data
            issue_pkg::OP_SW: begin
                dec.rs    = inst.i.rs;
                dec.rt    = inst.i.rt;
                dec.is_ls = 1'b1;
            end

            issue_pkg::OP_BEQ,
            issue_pkg::OP_BNE: begin
                dec.rs        = inst.i.rs;
                dec.rt        = inst.i.rt;
                dec.is_branch = 1'b1;
            end

            issue_pkg::OP_BEQL: begin
                dec.rs               = inst.i.rs;
                dec.rt               = inst.i.rt;
                dec.is_branch        = 1'b1;
                dec.is_branch_likely = 1'b1;
            end

            issue_pkg::OP_J: begin
                dec.is_j = 1'b1;
            end

            issue_pkg::OP_COP0: begin
                if (inst.r.rs == issue_pkg::CO_FMT && inst.r.funct == issue_pkg::CO_TLBWI) begin
                    dec.is_tlbw = 1'b1;
                end else if (inst.r.rs == issue_pkg::CO_FMT &&
                             inst.r.funct == issue_pkg::CO_TLBP) begin
                    dec.is_tlbp = 1'b1;
                end else begin
                    dec.is_ri = 1'b1;
                end
            end

            default: begin
                dec.is_ri = 1'b1;
            end
        endcase
    end

endmodule

//--- inst_queue.sv
`timescale 1ns/1ns

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  issue_pkg::fetch_entry_t entry,
    input  logic                    pop_1,
    input  logic                    pop_2,
    output logic                    full,
    output issue_pkg::fetch_entry_t head_1,
    output issue_pkg::fetch_entry_t head_2,
    output logic                    count_ge1,
    output logic                    count_ge2
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    issue_pkg::fetch_entry_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_p1;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic [1:0]       pop_num;

    assign push_ok   = push & ~full;
    assign pop_num   = {1'b0, pop_1} + {1'b0, pop_2};
    assign rd_ptr_p1 = rd_ptr + PTR_W'(1);

    assign full      = count == CNT_W'(QUEUE_DEPTH);
    assign count_ge1 = count != '0;
    assign count_ge2 = count >= CNT_W'(2);

    // second head wraps with the pointer, valid only when count_ge2
    assign head_1 = mem[rd_ptr];
    assign head_2 = mem[rd_ptr_p1];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            count  <= count + CNT_W'(push_ok) - CNT_W'(pop_num);
        end
    end

    // producer must hold the entry while full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    );

    a_pop2_needs_two: assert property (
        @(posedge clk) disable iff (rst) pop_2 |-> count_ge2
    );

    a_pop2_with_pop1: assert property (
        @(posedge clk) disable iff (rst) pop_2 |-> pop_1
    );

endmodule

//--- issue_frontend.f
issue_pkg.sv
inst_queue.sv
inst_decoder.sv
dual_issue.sv
issue_frontend.sv
tb_issue_frontend.sv

//--- issue_frontend.sv
`timescale 1ns/1ns

module issue_frontend #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    cls_refetch,
    input  logic                    push,
    input  issue_pkg::fetch_entry_t entry,
    output logic                    full,
    output issue_pkg::issue_slot_t  slot_1,
    output issue_pkg::issue_slot_t  slot_2,
    output logic [31:0]             dual_count,
    output logic [31:0]             single_count
);

    issue_pkg::fetch_entry_t head_1;
    issue_pkg::fetch_entry_t head_2;
    logic                    count_ge1;
    logic                    count_ge2;
    logic                    pop_1;
    logic                    pop_2;

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .entry     (entry),
        .pop_1     (pop_1),
        .pop_2     (pop_2),
        .full      (full),
        .head_1    (head_1),
        .head_2    (head_2),
        .count_ge1 (count_ge1),
        .count_ge2 (count_ge2)
    );

    dual_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .cls_refetch  (cls_refetch),
        .head_1       (head_1),
        .head_2       (head_2),
        .count_ge1    (count_ge1),
        .count_ge2    (count_ge2),
        .pop_1        (pop_1),
        .pop_2        (pop_2),
        .slot_1       (slot_1),
        .slot_2       (slot_2),
        .dual_count   (dual_count),
        .single_count (single_count)
    );

endmodule

//--- issue_pkg.sv
package issue_pkg;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_COP0    = 6'h10;
    localparam logic [5:0] OP_BEQL    = 6'h14;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // special funct field
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_MFHI    = 6'h10;
    localparam logic [5:0] FN_MULT    = 6'h18;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;

    // cop0 with the co bit set in rs, op in funct
    localparam logic [4:0] CO_FMT     = 5'h10;
    localparam logic [5:0] CO_TLBWI   = 6'h02;
    localparam logic [5:0] CO_TLBP    = 6'h08;

    typedef struct packed {
        logic        pred_taken;
        logic [31:0] pred_target;
        logic        itlb_refill;
        logic        itlb_invalid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_u;

    // rs and rt hold source registers only, zero when not read
    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  w_reg_dst;
        logic        w_reg_ena;
        logic [15:0] imm;
        logic        is_branch;
        logic        is_branch_likely;
        logic        is_j;
        logic        is_jr;
        logic        is_ls;
        logic        is_mul;
        logic        is_hilo;
        logic        is_tlbw;
        logic        is_tlbp;
        logic        is_ri;
    } decode_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        decode_t     dec;
        logic        in_delay_slot;
        logic        inst_adel;
        logic        itlb_refill;
        logic        itlb_invalid;
        logic        refetch;
        logic        pred_taken;
        logic [31:0] pred_target;
    } issue_slot_t;

endpackage

//--- tb_issue_frontend.sv
`timescale 1ns/1ns

module tb_issue_frontend;

    localparam int DEPTH       = 8;
    localparam int CYCLE_LIMIT = 2000;

    typedef struct packed {
        logic       ctl;
        logic       likely;
        logic       ls;
        logic       mul;
        logic       tlb;
        logic       tlbw;
        logic       ri;
        logic [4:0] dst;
        logic [4:0] src_a;
        logic [4:0] src_b;
    } inst_class_t;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic                    cls_refetch;
    logic                    push;
    issue_pkg::fetch_entry_t entry;
    logic                    full;
    issue_pkg::issue_slot_t  slot_1;
    issue_pkg::issue_slot_t  slot_2;
    logic [31:0]             dual_count;
    logic [31:0]             single_count;

    // reference model state
    issue_pkg::fetch_entry_t mq[$];
    issue_pkg::fetch_entry_t prog[$];
    logic                    m_ds = 1'b0;
    logic                    m_rf = 1'b0;
    int                      m_dual = 0;
    int                      m_single = 0;
    int                      dual_base;
    int                      single_base;
    int                      cycles = 0;
    logic [31:0]             lcg_state = 32'h3e0a;
    logic [31:0]             next_pc;
    string                   test_name = "reset";

    issue_frontend #(
        .QUEUE_DEPTH (DEPTH)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .cls_refetch  (cls_refetch),
        .push         (push),
        .entry        (entry),
        .full         (full),
        .slot_1       (slot_1),
        .slot_2       (slot_2),
        .dual_count   (dual_count),
        .single_count (single_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // tests take about a hundred cycles in all
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {issue_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // dst in r8..r15, sources in r16..r23, so never dependent
    function automatic logic [31:0] rand_alu();
        logic [31:0] r;
        logic [5:0]  fn;
        r = next_rand();
        case (r[1:0])
            2'd0: fn = issue_pkg::FN_ADDU;
            2'd1: fn = issue_pkg::FN_SUBU;
            2'd2: fn = issue_pkg::FN_AND;
            default: fn = issue_pkg::FN_OR;
        endcase
        return r_word(5'd16 + r[10:8], 5'd16 + r[14:12], 5'd8 + r[18:16], fn);
    endfunction

    function automatic inst_class_t classify(input logic [31:0] w);
        inst_class_t c;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic        spc;
        logic        alu;
        logic        cop;
        op  = w[31:26];
        fn  = w[5:0];
        spc = op == issue_pkg::OP_SPECIAL;
        cop = op == issue_pkg::OP_COP0 && w[25:21] == issue_pkg::CO_FMT;
        alu = spc && fn inside {issue_pkg::FN_ADDU, issue_pkg::FN_SUBU,
                                issue_pkg::FN_AND, issue_pkg::FN_OR};
        c.ls     = op inside {issue_pkg::OP_LW, issue_pkg::OP_SW};
        c.likely = op == issue_pkg::OP_BEQL;
        c.ctl    = op inside {issue_pkg::OP_BEQ, issue_pkg::OP_BNE, issue_pkg::OP_BEQL,
                              issue_pkg::OP_J} || (spc && fn == issue_pkg::FN_JR);
        c.mul    = spc && fn inside {issue_pkg::FN_MULT, issue_pkg::FN_MFHI};
        c.tlbw   = cop && fn == issue_pkg::CO_TLBWI;
        c.tlb    = c.tlbw || (cop && fn == issue_pkg::CO_TLBP);
        c.ri     = !(alu || c.ls || c.ctl || c.mul || c.tlb || op == issue_pkg::OP_ADDIU);
        if (alu || (spc && fn == issue_pkg::FN_MFHI)) begin
            c.dst = w[15:11];
        end else if (op inside {issue_pkg::OP_ADDIU, issue_pkg::OP_LW}) begin
            c.dst = w[20:16];
        end else begin
            c.dst = 5'd0;
        end
        c.src_a = (c.ri || c.tlb || op == issue_pkg::OP_J ||
                   (spc && fn == issue_pkg::FN_MFHI)) ? 5'd0 : w[25:21];
        c.src_b = (alu || (spc && fn == issue_pkg::FN_MULT) ||
                   op inside {issue_pkg::OP_SW, issue_pkg::OP_BEQ, issue_pkg::OP_BNE,
                              issue_pkg::OP_BEQL}) ? w[20:16] : 5'd0;
        return c;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // one cycle: drive at the falling edge, check mid-cycle, then advance the model
    task automatic step(input logic do_push, input issue_pkg::fetch_entry_t e,
                        input logic stl, input logic cls);
        inst_class_t c1;
        inst_class_t c2;
        logic        p1;
        logic        p2;
        logic        was_full;
        c1 = '0;
        c2 = '0;
        @(negedge clk);
        push        = do_push;
        entry       = e;
        stall       = stl;
        cls_refetch = cls;
        #10;
        was_full = mq.size() == DEPTH;
        p1 = mq.size() >= 1 && !stl;
        p2 = 1'b0;
        if (mq.size() >= 1) begin
            c1 = classify(mq[0].inst);
        end
        if (mq.size() >= 2) begin
            c2 = classify(mq[1].inst);
            p2 = p1 && !m_ds && !c2.ctl && !c2.ls && !c2.mul && !c2.ri && !c2.tlb &&
                 !c1.tlb && !c1.likely && mq[1].pc[1:0] == 2'b00 &&
                 !mq[1].itlb_refill && !mq[1].itlb_invalid &&
                 !(c1.dst != 5'd0 && (c1.dst == c2.src_a || c1.dst == c2.src_b));
        end
        check("full", was_full, full);
        check("slot_1.valid", p1, slot_1.valid);
        check("slot_2.valid", p2, slot_2.valid);
        if (p1) begin
            check("slot_1.pc", mq[0].pc, slot_1.pc);
            check("slot_1.inst", mq[0].inst, slot_1.inst);
            check("slot_1.inst_adel", mq[0].pc[1:0] != 2'b00, slot_1.inst_adel);
            check("slot_1.itlb_refill", mq[0].itlb_refill, slot_1.itlb_refill);
            check("slot_1.in_delay_slot", m_ds, slot_1.in_delay_slot);
            check("slot_1.refetch", m_rf, slot_1.refetch);
        end
        if (p2) begin
            check("slot_2.pc", mq[1].pc, slot_2.pc);
            check("slot_2.inst", mq[1].inst, slot_2.inst);
            check("slot_2.in_delay_slot", c1.ctl, slot_2.in_delay_slot);
            check("slot_2.refetch", m_rf, slot_2.refetch);
        end
        if (m_rf) begin
            m_rf = !cls;
        end else begin
            m_rf = p1 && c1.tlbw;
        end
        if (p1) begin
            m_ds = c1.ctl && !p2;
            void'(mq.pop_front());
        end
        if (p2) begin
            m_dual++;
            void'(mq.pop_front());
        end else if (p1) begin
            m_single++;
        end
        if (do_push && !was_full) begin
            mq.push_back(e);
        end
    endtask

    task automatic begin_test(input string name);
        logic [31:0] r;
        r           = next_rand();
        test_name   = name;
        dual_base   = m_dual;
        single_base = m_single;
        next_pc     = {r[27:4], 8'h00};
    endtask

    task automatic add(input logic [31:0] w);
        issue_pkg::fetch_entry_t e;
        e = '0;
        e.pc   = next_pc;
        e.inst = w;
        prog.push_back(e);
        next_pc = next_pc + 32'd4;
    endtask

    // pushes held behind stall so the queue fills up
    task automatic load();
        foreach (prog[i]) begin
            step(1'b1, prog[i], 1'b1, 1'b0);
        end
        prog.delete();
    endtask

    task automatic drain();
        while (mq.size() != 0) begin
            step(1'b0, '0, 1'b0, 1'b0);
        end
    endtask

    task automatic count_check(input int d, input int s);
        step(1'b0, '0, 1'b0, 1'b0);
        check("dual_count", dual_base + d, dual_count);
        check("single_count", single_base + s, single_count);
    endtask

    task automatic test_independent_pairs();
        begin_test("independent_pairs");
        repeat (8) add(rand_alu());
        load();
        drain();
        count_check(4, 0);
    endtask

    task automatic test_single_issue();
        begin_test("single_issue");
        add(r_word(5'd16, 5'd17, 5'd8, issue_pkg::FN_ADDU));
        add(r_word(5'd8, 5'd18, 5'd9, issue_pkg::FN_ADDU));
        add(r_word(5'd19, 5'd9, 5'd10, issue_pkg::FN_SUBU));
        add(r_word(5'd20, 5'd21, 5'd11, issue_pkg::FN_ADDU));
        add(r_word(5'd16, 5'd17, 5'd0, issue_pkg::FN_ADDU));
        add(r_word(5'd0, 5'd0, 5'd12, issue_pkg::FN_OR));
        add(i_word(issue_pkg::OP_LW, 5'd22, 5'd13, 16'h0010));
        add(i_word(issue_pkg::OP_SW, 5'd23, 5'd14, 16'h0020));
        load();
        drain();
        add(r_word(5'd16, 5'd17, 5'd8, issue_pkg::FN_ADDU));
        add(r_word(5'd18, 5'd19, 5'd0, issue_pkg::FN_MULT));
        add(r_word(5'd20, 5'd21, 5'd9, issue_pkg::FN_ADDU));
        add(r_word(5'd16, 5'd17, 5'd10, issue_pkg::FN_ADDU));
        add(r_word(5'd0, 5'd0, 5'd11, issue_pkg::FN_MFHI));
        add(r_word(5'd16, 5'd17, 5'd12, issue_pkg::FN_ADDU));
        add(r_word(5'd16, 5'd17, 5'd13, issue_pkg::FN_ADDU));
        add(32'hfc00_0000);
        load();
        drain();
        add(r_word(5'd16, 5'd17, 5'd8, issue_pkg::FN_ADDU));
        add(r_word(5'd18, 5'd19, 5'd9, issue_pkg::FN_ADDU));
        add(r_word(5'd20, 5'd21, 5'd10, issue_pkg::FN_ADDU));
        add(r_word(5'd16, 5'd17, 5'd11, issue_pkg::FN_ADDU));
        add(r_word(5'd18, 5'd19, 5'd12, issue_pkg::FN_ADDU));
        // second entry sits on a halfword address
        prog[1].pc = prog[1].pc + 32'd2;
        // last entry came back with an itlb refill
        prog[4].itlb_refill = 1'b1;
        load();
        drain();
        count_check(5, 11);
    endtask

    task automatic test_delay_slots();
        begin_test("delay_slots");
        add({issue_pkg::OP_J, 26'h000_0100});
        add(r_word(5'd16, 5'd17, 5'd8, issue_pkg::FN_ADDU));
        add(r_word(5'd18, 5'd19, 5'd9, issue_pkg::FN_ADDU));
        load();
        drain();
        add(i_word(issue_pkg::OP_BEQ, 5'd16, 5'd17, 16'h0004));
        add(i_word(issue_pkg::OP_LW, 5'd18, 5'd8, 16'h0000));
        add(r_word(5'd19, 5'd20, 5'd9, issue_pkg::FN_ADDU));
        load();
        drain();
        add(r_word(5'd16, 5'd0, 5'd0, issue_pkg::FN_JR));
        add(i_word(issue_pkg::OP_LW, 5'd17, 5'd8, 16'h0000));
        load();
        step(1'b0, '0, 1'b0, 1'b0);
        // stall between the jump and its delay slot
        repeat (3) step(1'b0, '0, 1'b1, 1'b0);
        drain();
        count_check(1, 6);
    endtask

    task automatic test_refetch();
        begin_test("refetch");
        add(r_word(5'd16, 5'd17, 5'd8, issue_pkg::FN_ADDU));
        add({issue_pkg::OP_COP0, issue_pkg::CO_FMT, 15'd0, issue_pkg::CO_TLBWI});
        add(r_word(5'd16, 5'd17, 5'd9, issue_pkg::FN_ADDU));
        add(r_word(5'd18, 5'd19, 5'd10, issue_pkg::FN_ADDU));
        add({issue_pkg::OP_COP0, issue_pkg::CO_FMT, 15'd0, issue_pkg::CO_TLBP});
        add(r_word(5'd20, 5'd21, 5'd11, issue_pkg::FN_ADDU));
        load();
        drain();
        step(1'b0, '0, 1'b0, 1'b1);
        add(r_word(5'd16, 5'd17, 5'd12, issue_pkg::FN_ADDU));
        add(r_word(5'd18, 5'd19, 5'd13, issue_pkg::FN_ADDU));
        load();
        drain();
        count_check(2, 4);
    endtask

    task automatic test_back_pressure();
        begin_test("back_pressure");
        repeat (DEPTH) add(rand_alu());
        load();
        repeat (2) step(1'b0, '0, 1'b1, 1'b0);
        drain();
        count_check(4, 0);
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        cls_refetch = 1'b0;
        push        = 1'b0;
        entry       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_independent_pairs();
        test_single_issue();
        test_delay_slots();
        test_refetch();
        test_back_pressure();
        $display("TEST PASS");
        $finish;
    end

endmodule
